/* logic/bp_pkg.sv */
package bp_pkg;

	// table and history sizing
	localparam int hist_bits   = 6;
	localparam int pht_entries = 2 ** hist_bits;

	// upper bit of the counter is the prediction
	typedef enum logic [1:0] {
		strong_nt = 2'b00,
		weak_nt   = 2'b01,
		weak_t    = 2'b10,
		strong_t  = 2'b11
	} ctr_t;

	typedef enum logic [1:0] {
		op_none = 2'b00,
		op_br   = 2'b01,
		op_jal  = 2'b10,
		op_jalr = 2'b11
	} br_op_t;

	localparam logic [31:0] reg_ctrl        = 32'h0000_0000; // bit0 enable, bit1 clear
	localparam logic [31:0] reg_status      = 32'h0000_0004; // bit0 busy
	localparam logic [31:0] reg_branches    = 32'h0000_0008;
	localparam logic [31:0] reg_mispredicts = 32'h0000_000c;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		logic                 taken;
		logic [hist_bits-1:0] hist; // history used for this lookup
	} fetch_pred_t;

	typedef struct packed {
		br_op_t               op;
		logic [31:0]          pc;
		logic                 actual;    // resolved direction
		logic [hist_bits-1:0] hist;      // history carried from fetch
		logic                 predicted;
	} resolve_t;

	typedef struct packed {
		logic valid;
		logic mispredict;
	} outcome_t;

	typedef struct packed {
		logic enable;
		logic clear; // one-cycle start of the table walk
	} bp_ctrl_t;

	typedef struct packed {
		logic        aw_valid;
		logic [31:0] aw_addr;
		logic        w_valid;
		logic [31:0] w_data;
		logic [3:0]  w_strb;
		logic        b_ready;
		logic        ar_valid;
		logic [31:0] ar_addr;
		logic        r_ready;
	} axil_req_t;

	typedef struct packed {
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		logic [1:0]  b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		logic [1:0]  r_resp;
	} axil_rsp_t;

endpackage

/* logic/gshare_predictor.sv */
`timescale 1ns/1ns

module gshare_predictor (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [31:0]         fetch_pc,
	input  bp_pkg::resolve_t    resolve,
	input  bp_pkg::bp_ctrl_t    ctrl,
	output bp_pkg::fetch_pred_t pred,
	output bp_pkg::outcome_t    outcome,
	output logic                busy
);

	typedef enum logic {
		idle,
		clearing
	} clr_state_t;

	bp_pkg::ctr_t pht [bp_pkg::pht_entries];

	logic [bp_pkg::hist_bits-1:0] hist;
	logic [bp_pkg::hist_bits-1:0] fetch_idx;
	logic [bp_pkg::hist_bits-1:0] train_idx;
	logic [bp_pkg::hist_bits-1:0] clr_addr;
	clr_state_t                   state;
	logic                         train;
	logic                         clr_start;

	// 2-bit saturating step
	function automatic bp_pkg::ctr_t ctr_next(input bp_pkg::ctr_t cur, input logic up);
		bp_pkg::ctr_t nxt;
		case (cur)
			bp_pkg::strong_nt: nxt = up ? bp_pkg::weak_nt : bp_pkg::strong_nt;
			bp_pkg::weak_nt:   nxt = up ? bp_pkg::weak_t : bp_pkg::strong_nt;
			bp_pkg::weak_t:    nxt = up ? bp_pkg::strong_t : bp_pkg::weak_nt;
			default:           nxt = up ? bp_pkg::strong_t : bp_pkg::weak_t;
		endcase
		return nxt;
	endfunction

	assign fetch_idx = fetch_pc[bp_pkg::hist_bits+1:2] ^ hist;
	assign train_idx = resolve.pc[bp_pkg::hist_bits+1:2] ^ resolve.hist; // index seen at fetch
	assign busy      = (state == clearing);
	assign clr_start = (state == idle) && ctrl.clear;
	assign train     = (resolve.op != bp_pkg::op_none) && !busy;

	// clear sequencer, one entry per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= idle;
			clr_addr <= '0;
		end else begin
			case (state)
				idle: begin
					if (ctrl.clear) begin
						state    <= clearing;
						clr_addr <= '0;
					end
				end
				default: begin
					clr_addr <= clr_addr + 1'b1;
					if (clr_addr == '1) begin
						state <= idle; // last entry written this cycle
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hist <= '0;
		end else if (clr_start) begin
			hist <= '0;
		end else if (train) begin
			hist <= {hist[bp_pkg::hist_bits-2:0], resolve.actual};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < bp_pkg::pht_entries; i++) begin
				pht[i] <= bp_pkg::weak_nt;
			end
		end else if (busy) begin
			pht[clr_addr] <= bp_pkg::weak_nt;
		end else if (train) begin
			pht[train_idx] <= ctr_next(pht[train_idx], resolve.actual);
		end
	end

	// fetch result and resolve outcome, both one cycle after sampling
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pred    <= '0;
			outcome <= '0;
		end else begin
			pred.taken         <= ctrl.enable && !busy && pht[fetch_idx][1];
			pred.hist          <= hist;
			outcome.valid      <= train;
			outcome.mispredict <= train && (resolve.predicted ^ resolve.actual);
		end
	end

endmodule

/* logic/bp_csr.sv */
`timescale 1ns/1ns

module bp_csr (
	input  logic              clk,
	input  logic              rst_n,
	input  bp_pkg::axil_req_t axil_req,
	output bp_pkg::axil_rsp_t axil_rsp,
	input  bp_pkg::outcome_t  outcome,
	input  logic              busy,
	output bp_pkg::bp_ctrl_t  ctrl
);

	logic        wr_fire;
	logic        rd_fire;
	logic        wr_ctrl;
	logic        wr_br;
	logic        wr_mis;
	logic        wr_mapped;
	logic        rd_mapped;
	logic [31:0] rd_mux;

	logic        b_valid;
	logic [1:0]  b_resp;
	logic        r_valid;
	logic [1:0]  r_resp;
	logic [31:0] r_data;

	logic        enable;
	logic        clear_pulse;
	logic [31:0] br_cnt;
	logic [31:0] mis_cnt;

	function automatic logic [31:0] sat_inc(input logic [31:0] cnt);
		logic [31:0] nxt;
		nxt = (cnt == '1) ? cnt : cnt + 32'd1;
		return nxt;
	endfunction

	// aw and w accepted together, only with no B pending
	assign wr_fire = axil_req.aw_valid && axil_req.w_valid && !b_valid;
	assign rd_fire = axil_req.ar_valid && !r_valid;

	assign wr_ctrl   = wr_fire && (axil_req.aw_addr == bp_pkg::reg_ctrl);
	assign wr_br     = wr_fire && (axil_req.aw_addr == bp_pkg::reg_branches);
	assign wr_mis    = wr_fire && (axil_req.aw_addr == bp_pkg::reg_mispredicts);
	assign wr_mapped = (axil_req.aw_addr == bp_pkg::reg_ctrl) ||
		(axil_req.aw_addr == bp_pkg::reg_status) ||
		(axil_req.aw_addr == bp_pkg::reg_branches) ||
		(axil_req.aw_addr == bp_pkg::reg_mispredicts); // status takes writes, ignores them

	always_comb begin
		rd_mapped = 1'b1;
		case (axil_req.ar_addr)
			bp_pkg::reg_ctrl:        rd_mux = {31'd0, enable}; // clear reads as 0
			bp_pkg::reg_status:      rd_mux = {31'd0, busy};
			bp_pkg::reg_branches:    rd_mux = br_cnt;
			bp_pkg::reg_mispredicts: rd_mux = mis_cnt;
			default: begin
				rd_mux    = '0;
				rd_mapped = 1'b0;
			end
		endcase
	end

	always_comb begin
		axil_rsp.aw_ready = wr_fire;
		axil_rsp.w_ready  = wr_fire;
		axil_rsp.b_valid  = b_valid;
		axil_rsp.b_resp   = b_resp;
		axil_rsp.ar_ready = !r_valid;
		axil_rsp.r_valid  = r_valid;
		axil_rsp.r_data   = r_data;
		axil_rsp.r_resp   = r_resp;
	end

	// write response channel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			b_valid <= 1'b0;
			b_resp  <= bp_pkg::resp_okay;
		end else if (wr_fire) begin
			b_valid <= 1'b1;
			b_resp  <= wr_mapped ? bp_pkg::resp_okay : bp_pkg::resp_slverr;
		end else if (axil_req.b_ready) begin
			b_valid <= 1'b0;
		end
	end

	// read data channel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_valid <= 1'b0;
			r_resp  <= bp_pkg::resp_okay;
		end else if (rd_fire) begin
			r_valid <= 1'b1;
			r_resp  <= rd_mapped ? bp_pkg::resp_okay : bp_pkg::resp_slverr;
		end else if (axil_req.r_ready) begin
			r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_data <= rd_mux;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable      <= 1'b0;
			clear_pulse <= 1'b0;
		end else begin
			clear_pulse <= wr_ctrl && axil_req.w_strb[0] && axil_req.w_data[1]; // self-clearing
			if (wr_ctrl && axil_req.w_strb[0]) begin
				enable <= axil_req.w_data[0];
			end
		end
	end

	// statistics, a write in the same cycle wins over an outcome
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			br_cnt  <= '0;
			mis_cnt <= '0;
		end else begin
			if (wr_br) begin
				br_cnt <= '0;
			end else if (outcome.valid) begin
				br_cnt <= sat_inc(br_cnt);
			end
			if (wr_mis) begin
				mis_cnt <= '0;
			end else if (outcome.valid && outcome.mispredict) begin
				mis_cnt <= sat_inc(mis_cnt);
			end
		end
	end

	assign ctrl.enable = enable;
	assign ctrl.clear  = clear_pulse;

endmodule

/* logic/bp_top.sv */
`timescale 1ns/1ns

module bp_top (
	input  logic                clk,
	input  logic                rst_n,

	// fetch side
	input  logic [31:0]         fetch_pc,
	output bp_pkg::fetch_pred_t pred,

	// execute side
	input  bp_pkg::resolve_t    resolve,

	// register bus
	input  bp_pkg::axil_req_t   axil_req,
	output bp_pkg::axil_rsp_t   axil_rsp
);

	bp_pkg::bp_ctrl_t ctrl;
	bp_pkg::outcome_t outcome;
	logic             busy;

	gshare_predictor u_predictor (
		.clk      (clk),
		.rst_n    (rst_n),
		.fetch_pc (fetch_pc),
		.resolve  (resolve),
		.ctrl     (ctrl),
		.pred     (pred),
		.outcome  (outcome),
		.busy     (busy)
	);

	// control bits, status and statistics
	bp_csr u_csr (
		.clk      (clk),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.outcome  (outcome),
		.busy     (busy),
		.ctrl     (ctrl)
	);

endmodule

/* dv/bp_tb.sv */
`timescale 1ns/1ns

module bp_tb;

	typedef struct packed {
		logic [7:0]  cmd;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		logic [31:0] a4;
	} golden_cmd_t;

	logic                clk;
	logic                rst_n;
	logic [31:0]         fetch_pc;
	bp_pkg::fetch_pred_t pred;
	bp_pkg::resolve_t    resolve;
	bp_pkg::axil_req_t   axil_req;
	bp_pkg::axil_rsp_t   axil_rsp;

	golden_cmd_t cmds[$];
	bit          loaded;

	bp_top DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.fetch_pc (fetch_pc),
		.pred     (pred),
		.resolve  (resolve),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	always #50 clk = ~clk;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_pred(input bp_pkg::fetch_pred_t got, input bp_pkg::fetch_pred_t exp);
		if (got !== exp) begin
			stop_run($sformatf("FAIL %0t: pred taken=%0b hist=%h, expected taken=%0b hist=%h",
				$time, got.taken, got.hist, exp.taken, exp.hist));
		end
	endtask

	task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	// aw and w offered together, B taken after a random stall
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic accepted;
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr  = addr;
		axil_req.w_valid  = 1'b1;
		axil_req.w_data   = data;
		axil_req.w_strb   = 4'hf;
		accepted = 1'b0;
		while (!accepted) begin
			#1 accepted = axil_rsp.aw_ready && axil_rsp.w_ready; // settled before the edge
			@(negedge clk);
		end
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid  = 1'b0;
		repeat ($urandom % 4) @(negedge clk);
		axil_req.b_ready = 1'b1;
		#1;
		if (!axil_rsp.b_valid) begin
			stop_run("write response was not held while b_ready was low");
		end
		resp = axil_rsp.b_resp;
		@(negedge clk);
		axil_req.b_ready = 1'b0;
		if (axil_rsp.b_valid) begin
			stop_run("write response was delivered more than once");
		end
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic accepted;
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr  = addr;
		accepted = 1'b0;
		while (!accepted) begin
			#1 accepted = axil_rsp.ar_ready;
			@(negedge clk);
		end
		axil_req.ar_valid = 1'b0;
		repeat ($urandom % 4) @(negedge clk);
		axil_req.r_ready = 1'b1;
		#1;
		if (!axil_rsp.r_valid) begin
			stop_run("read response was not held while r_ready was low");
		end
		data = axil_rsp.r_data;
		resp = axil_rsp.r_resp;
		@(negedge clk);
		axil_req.r_ready = 1'b0;
		if (axil_rsp.r_valid) begin
			stop_run("read response was delivered more than once");
		end
	endtask

	task automatic do_fetch(input logic [31:0] pc, output bp_pkg::fetch_pred_t got);
		fetch_pc = pc;
		@(negedge clk); // pred registered at the edge in between
		got = pred;
	endtask

	task automatic do_resolve(input golden_cmd_t c);
		resolve.op        = bp_pkg::br_op_t'(c.a0[1:0]);
		resolve.pc        = c.a1;
		resolve.actual    = c.a2[0];
		resolve.hist      = c.a3[bp_pkg::hist_bits-1:0];
		resolve.predicted = c.a4[0];
		@(negedge clk);
		resolve.op = bp_pkg::op_none;
	endtask

	task automatic run_command(input golden_cmd_t c);
		logic [1:0]          resp;
		logic [31:0]         data;
		bp_pkg::fetch_pred_t got;
		bp_pkg::fetch_pred_t exp;
		case (c.cmd)
			"W": begin
				axil_write(c.a0, c.a1, resp);
				check_resp(resp, c.a2[1:0], $sformatf("write resp at %h", c.a0));
			end
			"R": begin
				axil_read(c.a0, data, resp);
				check_rdata(data, c.a1, $sformatf("read data at %h", c.a0));
				check_resp(resp, c.a2[1:0], $sformatf("read resp at %h", c.a0));
			end
			"F": begin
				do_fetch(c.a0, got);
				exp.taken = c.a1[0];
				exp.hist  = c.a2[bp_pkg::hist_bits-1:0];
				check_pred(got, exp);
			end
			"U": do_resolve(c);
			"C": repeat (c.a0) @(negedge clk);
			"E": begin
				axil_read(bp_pkg::reg_mispredicts, data, resp);
				check_rdata(data, c.a0, "mispredict count");
				check_resp(resp, bp_pkg::resp_okay, "mispredict count resp");
			end
			default: stop_run($sformatf("golden file holds an unknown command %c", c.cmd));
		endcase
	endtask

	initial begin
		int                fd;
		logic [7:0]        ch;
		logic [8*128-1:0]  rest;
		logic [31:0]       a0;
		logic [31:0]       a1;
		logic [31:0]       a2;
		logic [31:0]       a3;
		logic [31:0]       a4;
		golden_cmd_t       c;
		clk      = 1'b0;
		rst_n    = 1'b0;
		fetch_pc = '0;
		resolve  = '0;
		axil_req = '0;
		void'($urandom(32'h1418));
		fd = $fopen("dv/bp_golden.txt", "r");
		if (fd == 0) begin
			stop_run("could not open dv/bp_golden.txt");
		end
		while ($fscanf(fd, " %c", ch) == 1) begin
			rest = '0;
			void'($fgets(rest, fd));
			if (ch != "#") begin // comment lines are skipped whole
				{a0, a1, a2, a3, a4} = '0;
				void'($sscanf(rest, "%h %h %h %h %h", a0, a1, a2, a3, a4));
				c = {ch, a0, a1, a2, a3, a4};
				cmds.push_back(c);
			end
		end
		$fclose(fd);
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (cmds[i]) begin
			run_command(cmds[i]);
		end
		$display("All checks passed");
		$finish;
	end

	// watchdog sized from the command count
	initial begin
		wait (loaded);
		repeat (cmds.size() * 20 + bp_pkg::pht_entries + 50) @(posedge clk);
		stop_run("simulation timed out before the golden commands completed");
	end

endmodule

/* dv/bp_golden.txt */
# W addr data resp | R addr data resp | F pc taken hist | C cycles | E mispredicts
# U op pc actual hist predicted (every field hex)
R 0 0 0
R 4 0 0
R 8 0 0
R c 0 0
F 100 0 0
W 0 1 0
R 0 1 0
F 10 0 0
U 1 10 1 0 0
F 14 1 1
U 1 14 1 1 1
F 1c 1 3
U 1 1c 0 3 1
F 8 1 6
U 1 8 0 6 1
F 20 0 c
U 1 20 0 c 0
F 70 0 18
U 0 20 1 18 0
U 2 40 1 18 1
F 40 0 31
R 8 6 0
E 3
W 8 0 0
R 8 0 0
W c 0 0
E 0
W 0 3 0
R 4 1 0
F 40 0 0
U 1 40 1 0 1
C 48
R 4 0 0
R 8 0 0
E 0
F 20 0 0
R 20 0 2
W 24 5 2

/* compile.f */
logic/bp_pkg.sv
logic/gshare_predictor.sv
logic/bp_csr.sv
logic/bp_top.sv
dv/bp_tb.sv

/* Bender.yml */
package:
  name: bp_gshare

sources:
  - logic/bp_pkg.sv
  - logic/gshare_predictor.sv
  - logic/bp_csr.sv
  - logic/bp_top.sv
  - target: simulation
    files:
      - dv/bp_tb.sv
